// ==== hdl/mipsPkg.sv ====
/*
 * MIPS execute stage shared definitions: data and register widths,
 * opcode, funct and REGIMM codes, instruction class and the
 * instruction word union with its R, I and J views
 */

`default_nettype none

package mipsPkg;

    localparam int WORD_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_COUNT      = 32;

    typedef logic [WORD_WIDTH-1:0]     wordT;
    typedef logic [REG_ADDR_WIDTH-1:0] regAddrT;

    // primary opcodes, bits 31:26
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // funct field of SPECIAL, bits 5:0
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // REGIMM branches are selected by the rt field
    localparam logic [4:0] RI_BLTZ = 5'h00;
    localparam logic [4:0] RI_BGEZ = 5'h01;

    typedef enum logic [1:0] {
        CLS_NONE,
        CLS_R,
        CLS_I,
        CLS_J  // jumps and all branches
    } insnClassT;

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            regAddrT    rs;
            regAddrT    rt;
            regAddrT    rd;
            logic [4:0] sa;
            logic [5:0] funct;
        } rFmt;
        struct packed {
            logic [5:0]  opcode;
            regAddrT     rs;
            regAddrT     rt;
            logic [15:0] imm;  // also the branch offset
        } iFmt;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] index;
        } jFmt;
    } insnT;

endpackage

`default_nettype wire

// ==== hdl/insnDecoder.sv ====
/*
 * Instruction decoder: sorts the word into R, I or J class and
 * picks the destination register and its write enable
 */

`default_nettype none

module insnDecoder (
    input  mipsPkg::insnT      insn,
    output mipsPkg::insnClassT insnClass,
    output mipsPkg::regAddrT   destReg,
    output logic               writeEn
);
    import mipsPkg::*;

    always_comb begin
        insnClass = CLS_NONE;
        case (insn.rFmt.opcode)
            OP_SPECIAL: begin
                case (insn.rFmt.funct)
                    FN_SLL, FN_SRL, FN_SRA,
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                    FN_AND, FN_OR, FN_XOR, FN_NOR,
                    FN_SLT, FN_SLTU: begin
                        insnClass = CLS_R;
                    end
                    default: begin
                        insnClass = CLS_NONE;  // unknown funct
                    end
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_ORI, OP_LUI: begin
                insnClass = CLS_I;
            end
            OP_J, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                insnClass = CLS_J;
            end
            OP_REGIMM: begin
                if (insn.iFmt.rt == RI_BLTZ || insn.iFmt.rt == RI_BGEZ) begin
                    insnClass = CLS_J;
                end
            end
            default: begin
                insnClass = CLS_NONE;  // loads, stores and the rest
            end
        endcase
    end

    // rd for R, rt for immediates, nothing written otherwise
    always_comb begin
        case (insnClass)
            CLS_R: begin
                destReg = insn.rFmt.rd;
            end
            CLS_I: begin
                destReg = insn.iFmt.rt;
            end
            default: begin
                destReg = '0;
            end
        endcase
    end

    assign writeEn = (insnClass == CLS_R) || (insnClass == CLS_I);

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
/*
 * 32 x 32-bit register file, two combinational read ports,
 * one write port, zero register and write-through bypass
 */

`default_nettype none

module regFile (
    input  logic             clock,
    input  logic             arstN,
    input  mipsPkg::regAddrT rsAddr,
    input  mipsPkg::regAddrT rtAddr,
    input  mipsPkg::regAddrT writeAddr,
    input  mipsPkg::wordT    writeData,
    input  logic             writeEn,
    output mipsPkg::wordT    rsData,
    output mipsPkg::wordT    rtData
);
    import mipsPkg::*;

    wordT regs [1:REG_COUNT-1];  // no storage for r0

    function automatic wordT readPort(input regAddrT addr);
        if (addr == '0) begin
            return '0;
        end
        if (writeEn && addr == writeAddr) begin
            return writeData;  // bypass the pending write
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    always_comb begin
        rsData = readPort(rsAddr);
        rtData = readPort(rtAddr);
    end

    // the writeback path upstream drops r0 destinations
    noZeroWrite: assert property (
        @(posedge clock) disable iff (!arstN)
        writeEn |-> writeAddr != '0
    );

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
/*
 * Registered ALU: arithmetic, logic, shifts, compares,
 * jump target and branch evaluation, one result per instruction
 */

`default_nettype none

module alu (
    input  logic               clock,
    input  logic               arstN,
    input  logic               insnValid,
    input  mipsPkg::insnT      insn,
    input  mipsPkg::insnClassT insnClass,
    input  mipsPkg::wordT      pc,
    input  mipsPkg::wordT      rsData,
    input  mipsPkg::wordT      rtData,
    output mipsPkg::wordT      result,
    output logic               resultValid,
    output logic               branchTaken
);
    import mipsPkg::*;

    wordT pcPlus4;
    wordT immSext;
    wordT immZext;
    wordT branchTarget;
    wordT nextResult;
    logic nextTaken;
    logic isBranch;

    assign pcPlus4      = pc + WORD_WIDTH'(4);
    assign immSext      = {{16{insn.iFmt.imm[15]}}, insn.iFmt.imm};
    assign immZext      = {16'b0, insn.iFmt.imm};
    assign branchTarget = pcPlus4 + {immSext[WORD_WIDTH-3:0], 2'b00};

    always_comb begin
        nextResult = '0;
        nextTaken  = 1'b0;
        isBranch   = 1'b0;
        case (insnClass)
            CLS_R: begin
                case (insn.rFmt.funct)
                    FN_ADD, FN_ADDU: nextResult = rsData + rtData;  // no overflow trap
                    FN_SUB, FN_SUBU: nextResult = rsData - rtData;
                    FN_AND:  nextResult = rsData & rtData;
                    FN_OR:   nextResult = rsData | rtData;
                    FN_XOR:  nextResult = rsData ^ rtData;
                    FN_NOR:  nextResult = ~(rsData | rtData);
                    FN_SLT:  nextResult = wordT'($signed(rsData) < $signed(rtData));
                    FN_SLTU: nextResult = wordT'(rsData < rtData);
                    FN_SLL:  nextResult = rtData << insn.rFmt.sa;
                    FN_SRL:  nextResult = rtData >> insn.rFmt.sa;
                    FN_SRA:  nextResult = $signed(rtData) >>> insn.rFmt.sa;
                    default: nextResult = '0;
                endcase
            end
            CLS_I: begin
                case (insn.iFmt.opcode)
                    OP_ADDIU: nextResult = rsData + immSext;
                    OP_SLTI:  nextResult = wordT'($signed(rsData) < $signed(immSext));
                    OP_ORI:   nextResult = rsData | immZext;
                    OP_LUI:   nextResult = {insn.iFmt.imm, 16'b0};
                    default:  nextResult = '0;
                endcase
            end
            CLS_J: begin
                isBranch = 1'b1;
                case (insn.jFmt.opcode)
                    OP_J: begin
                        isBranch   = 1'b0;
                        nextResult = {pcPlus4[31:28], insn.jFmt.index, 2'b00};
                    end
                    OP_BEQ:  nextTaken = (rsData == rtData);
                    OP_BNE:  nextTaken = (rsData != rtData);
                    OP_BLEZ: nextTaken = rsData[31] || (rsData == '0);
                    OP_BGTZ: nextTaken = !rsData[31] && (rsData != '0);
                    OP_REGIMM: begin
                        // sign bit alone decides both
                        if (insn.iFmt.rt == RI_BLTZ) begin
                            nextTaken = rsData[31];
                        end else if (insn.iFmt.rt == RI_BGEZ) begin
                            nextTaken = !rsData[31];
                        end
                    end
                    default: begin
                        isBranch = 1'b0;
                    end
                endcase
                if (isBranch) begin
                    nextResult = nextTaken ? branchTarget : pcPlus4;
                end
            end
            default: begin
                nextResult = '0;  // unsupported, still reported
            end
        endcase
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            result      <= '0;
            resultValid <= 1'b0;
            branchTaken <= 1'b0;
        end else begin
            resultValid <= insnValid;
            branchTaken <= insnValid && nextTaken;
            if (insnValid) begin
                result <= nextResult;
            end
        end
    end

    takenNeedsValid: assert property (
        @(posedge clock) disable iff (!arstN)
        branchTaken |-> resultValid
    );

    // one pulse per offered instruction
    validIsPulse: assert property (
        @(posedge clock) disable iff (!arstN)
        !insnValid |=> !resultValid
    );

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
/*
 * Execute stage top: decoder, register file and ALU, plus the
 * destination and write-enable registers for writeback
 */

`default_nettype none

module executeStage (
    input  logic             clock,
    input  logic             arstN,
    input  logic             insnValid,
    input  mipsPkg::insnT    insn,
    input  mipsPkg::wordT    pc,
    output mipsPkg::wordT    result,
    output logic             resultValid,
    output logic             branchTaken,
    output mipsPkg::regAddrT destOut,
    output logic             writeOut
);
    import mipsPkg::*;

    insnClassT insnClass;
    regAddrT   destReg;
    logic      writeEn;
    wordT      rsData;
    wordT      rtData;
    logic      rfWriteEn;

    insnDecoder decoder (
        .insn      (insn),
        .insnClass (insnClass),
        .destReg   (destReg),
        .writeEn   (writeEn)
    );

    // r0 destinations are reported but never reach the file
    assign rfWriteEn = resultValid && writeOut && (destOut != '0);

    regFile regs (
        .clock     (clock),
        .arstN     (arstN),
        .rsAddr    (insn.rFmt.rs),
        .rtAddr    (insn.rFmt.rt),
        .writeAddr (destOut),
        .writeData (result),
        .writeEn   (rfWriteEn),
        .rsData    (rsData),
        .rtData    (rtData)
    );

    alu execAlu (
        .clock       (clock),
        .arstN       (arstN),
        .insnValid   (insnValid),
        .insn        (insn),
        .insnClass   (insnClass),
        .pc          (pc),
        .rsData      (rsData),
        .rtData      (rtData),
        .result      (result),
        .resultValid (resultValid),
        .branchTaken (branchTaken)
    );

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            writeOut <= 1'b0;
        end else begin
            writeOut <= insnValid && writeEn;
        end
    end

    always_ff @(posedge clock) begin
        if (insnValid) begin
            destOut <= destReg;  // travels with the ALU result
        end
    end

endmodule

`default_nettype wire

// ==== tests/executeStageTb.sv ====
/*
 * Testbench for the execute stage: clock, reset, replay of the
 * golden instruction file and typed compare tasks
 */

`default_nettype none

module executeStageTb;
    import mipsPkg::*;

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 2;
    localparam int MAX_IDLE     = 3;  // idle cycles between instructions

    logic    clock;
    logic    arstN;
    logic    insnValid;
    insnT    insn;
    wordT    pc;
    wordT    result;
    logic    resultValid;
    logic    branchTaken;
    regAddrT destOut;
    logic    writeOut;

    // one entry per golden line
    wordT    goldPc [$];
    wordT    goldInsn [$];
    wordT    goldResult [$];
    logic    goldTaken [$];
    regAddrT goldDest [$];
    logic    goldWrite [$];

    int cycleCount;
    int cycleLimit;

    executeStage uut (
        .clock       (clock),
        .arstN       (arstN),
        .insnValid   (insnValid),
        .insn        (insn),
        .pc          (pc),
        .result      (result),
        .resultValid (resultValid),
        .branchTaken (branchTaken),
        .destOut     (destOut),
        .writeOut    (writeOut)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input wordT actual, input wordT expected);
        if (actual !== expected) begin
            abortRun($sformatf("** Error at %0t: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abortRun($sformatf("** Error at %0t: %s is %b, expected %b",
                               $time, name, actual, expected));
        end
    endtask

    task automatic checkReg(input string name, input regAddrT actual, input regAddrT expected);
        if (actual !== expected) begin
            abortRun($sformatf("** Error at %0t: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic loadGolden();
        int    fd;
        int    fields;
        string line;
        wordT  colPc;
        wordT  colInsn;
        wordT  colResult;
        wordT  colTaken;
        wordT  colDest;
        wordT  colWrite;
        fd = $fopen("tests/executeGolden.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open golden file tests/executeGolden.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h", colPc, colInsn,
                                     colResult, colTaken, colDest, colWrite);
                    if (fields != 6) begin
                        abortRun({"malformed line in golden file: ", line});
                    end else begin
                        goldPc.push_back(colPc);
                        goldInsn.push_back(colInsn);
                        goldResult.push_back(colResult);
                        goldTaken.push_back(colTaken[0]);
                        goldDest.push_back(regAddrT'(colDest));
                        goldWrite.push_back(colWrite[0]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // outputs one cycle after instruction idx was offered
    task automatic checkResult(input int idx);
        if (resultValid !== 1'b1) begin
            abortRun($sformatf("resultValid missing one cycle after insnValid, instruction %0d",
                               idx + 1));
        end else begin
            checkWord("result", result, goldResult[idx]);
            checkFlag("branchTaken", branchTaken, goldTaken[idx]);
            checkReg("destOut", destOut, goldDest[idx]);
            checkFlag("writeOut", writeOut, goldWrite[idx]);
        end
    endtask

    task automatic stepCycle(input logic valid, input int idx);
        insnValid = valid;
        if (valid) begin
            insn = goldInsn[idx];
            pc   = goldPc[idx];
        end
        @(posedge clock);
        #DRIVE_DELAY;
        if (valid) begin
            checkResult(idx);
        end else if (resultValid !== 1'b0) begin
            abortRun("resultValid high although insnValid was low the cycle before");
        end
    endtask

    always @(posedge clock) begin
        if (arstN) begin
            cycleCount = cycleCount + 1;
            if (cycleCount > cycleLimit) begin
                abortRun($sformatf("timeout after %0d cycles", cycleCount));
            end
        end
    end

    initial begin
        int idle;
        void'($urandom(32'hfc7d_a61f));
        arstN      = 1'b0;
        insnValid  = 1'b0;
        insn       = '0;
        pc         = '0;
        cycleCount = 0;
        loadGolden();
        cycleLimit = 2 * goldInsn.size() + MAX_IDLE * goldInsn.size() + 20;

        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        checkWord("result", result, '0);
        checkFlag("resultValid", resultValid, 1'b0);
        checkFlag("branchTaken", branchTaken, 1'b0);
        checkFlag("writeOut", writeOut, 1'b0);
        arstN = 1'b1;

        for (int i = 0; i < goldInsn.size(); i++) begin
            idle = $urandom % (MAX_IDLE + 1);  // zero gives back-to-back issue
            repeat (idle) stepCycle(1'b0, 0);
            stepCycle(1'b1, i);
        end
        stepCycle(1'b0, 0);  // no stray pulse after the last one

        if (goldInsn.size() == 0) begin
            abortRun("golden file holds no instructions");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/executeGolden.txt ====
# columns in hex: pc insn result branchTaken destOut writeOut
# registers build up line by line, r1..r6 feed compares, shifts and branches
00400000 00400825 00000000 0 01 1
00400004 03e01825 00000000 0 03 1
00400008 3c018000 80000000 0 01 1
0040000c 34210001 80000001 0 01 1
00400010 3c027fff 7fff0000 0 02 1
00400014 3442ffff 7fffffff 0 02 1
00400018 00221820 00000000 0 03 1
0040001c 00422021 fffffffe 0 04 1
00400020 00612822 7fffffff 0 05 1
00400024 00223023 00000002 0 06 1
00400028 00243824 80000000 0 07 1
0040002c 00264025 80000003 0 08 1
00400030 00824826 80000001 0 09 1
00400034 00265027 7ffffffc 0 0a 1
00400038 0026582a 00000001 0 0b 1
0040003c 0026602b 00000000 0 0c 1
00400040 282d0005 00000001 0 0d 1
00400044 28ceffff 00000000 0 0e 1
00400048 00017800 80000001 0 0f 1
0040004c 00018040 00000002 0 10 1
00400050 0001b7c0 80000000 0 16 1
00400054 00018842 40000000 0 11 1
00400058 000197c2 00000001 0 12 1
0040005c 00019843 c0000000 0 13 1
00400060 0001a7c3 ffffffff 0 14 1
00400064 0002afc3 00000000 0 15 1
00400068 10450004 0040007c 1 00 0
0040006c 1022fffe 00400070 0 00 0
00400070 1422fffd 00400068 1 00 0
00400074 14600008 00400078 0 00 0
00400078 1cc00010 004000bc 1 00 0
0040007c 1c600010 00400080 0 00 0
00400080 1860ffff 00400080 1 00 0
00400084 18c00004 00400088 0 00 0
00400088 0420fff8 0040006c 1 00 0
0040008c 04400002 00400090 0 00 0
00400090 04610020 00400114 1 00 0
00400094 04810001 00400098 0 00 0
90000010 08123456 9048d158 0 00 0
0ffffffc 0bffffff 1ffffffc 0 00 0
004000a0 8c270000 00000000 0 00 0
004000a4 ac270000 00000000 0 00 0
004000a8 0022483f 00000000 0 00 0
004000ac 0120b825 80000001 0 17 1
004000b0 24200005 80000006 0 00 1
004000b4 0006c021 00000002 0 18 1
004000b8 24d9fffd ffffffff 0 19 1

// ==== all.f ====
hdl/mipsPkg.sv
hdl/insnDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/executeStage.sv
tests/executeStageTb.sv

// ==== Makefile ====
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= executeStageTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
